// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // ------------------------------------------------------------------
    // Basic types
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        NOP,
        ALU,
        LW,
        LH,
        LHU,
        LB,
        SW,
        SH,
        SB,
        SYSCALL,
        BREAK,
        ERET,
        MTC0
    } decoded_op_t;

    typedef struct packed {
        decoded_op_t op;
    } instr_info_t;

    // Record handed over from the memory stage
    typedef struct packed {
        logic        valid;
        instr_info_t instr;
        word_t       pcplus4;
        word_t       result;            // ALU result or memory address
        logic        exception_instr;   // Fetch address error
        logic        exception_ri;
        logic        exception_of;
        logic        in_delay_slot;
    } exec_data_t;

    typedef struct packed {
        logic  instr;
        logic  ri;
        logic  of;
        logic  load;
        logic  save;
        logic  sys;
        logic  bp;
        word_t pc;
        word_t vaddr;
        logic  in_delay_slot;
    } fault_flags_t;

    // ------------------------------------------------------------------
    // Exceptions and CP0
    // ------------------------------------------------------------------
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
        logic      badvaddr_we;
        logic      bd;
        logic      is_eret;
    } exception_t;

    typedef struct packed {
        logic [7:0] IM;
        logic       EXL;
        logic       IE;
    } cp0_status_t;

    typedef struct packed {
        logic       BD;
        logic [7:0] IP;                 // Only IP1..0 are software writable
        exc_code_t  exc_code;
    } cp0_cause_t;

    typedef struct packed {
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       badvaddr;
    } cp0_view_t;

    localparam word_t      EXC_VECTOR      = 32'hBFC0_0380;
    localparam logic [4:0] CP0_STATUS_ADDR = 5'd12;
    localparam logic [4:0] CP0_CAUSE_ADDR  = 5'd13;
    localparam logic [4:0] CP0_EPC_ADDR    = 5'd14;

endpackage

`default_nettype wire

// ==== verilog/fault_detector.sv ====
`default_nettype none

module fault_detector (
    input  mips_pkg::exec_data_t   rec,
    output mips_pkg::fault_flags_t flags
);

    import mips_pkg::*;

    decoded_op_t op;
    word_t       addr;
    word_t       pc;
    logic        word_misaligned;
    logic        half_misaligned;

    assign op   = rec.instr.op;
    assign addr = rec.result;
    assign pc   = rec.pcplus4 - 32'd4;

    assign word_misaligned = (addr[1:0] != 2'b00);
    assign half_misaligned = addr[0];

    // ------------------------------------------------------------------
    // Flag derivation
    // ------------------------------------------------------------------
    always_comb begin
        flags = '0;

        // Faults flagged by earlier stages
        flags.instr = rec.exception_instr;
        flags.ri    = rec.exception_ri;
        flags.of    = rec.exception_of;

        flags.sys = (op == SYSCALL);
        flags.bp  = (op == BREAK);

        // Byte accesses can never be misaligned
        flags.load = ((op == LW) && word_misaligned) ||
                     ((op == LH || op == LHU) && half_misaligned);
        flags.save = ((op == SW) && word_misaligned) ||
                     ((op == SH) && half_misaligned);

        flags.pc            = pc;
        flags.vaddr         = rec.exception_instr ? pc : addr;  // Fetch fault reports the PC
        flags.in_delay_slot = rec.in_delay_slot;
    end

endmodule

`default_nettype wire

// ==== verilog/interrupt_collector.sv ====
`default_nettype none

module interrupt_collector (
    input  logic [5:0]            ext_int,
    input  logic                  timer_interrupt,
    input  mips_pkg::cp0_status_t cp0_status,
    input  mips_pkg::cp0_cause_t  cp0_cause,
    output logic [7:0]            pending
);

    logic [7:0] hw_src;
    logic [7:0] sw_src;
    logic [7:0] timer_src;
    logic [7:0] raw;

    // ------------------------------------------------------------------
    // Sources mapped onto IP positions
    // ------------------------------------------------------------------
    assign hw_src    = {ext_int, 2'b00};                // IP7..2
    assign sw_src    = {6'b00_0000, cp0_cause.IP[1:0]}; // IP1..0
    assign timer_src = {timer_interrupt, 7'b000_0000};  // Shares IP7 with ext_int[5]

    assign raw = hw_src | sw_src | timer_src;

    // Enable and EXL are checked by the arbiter
    assign pending = raw & cp0_status.IM;

endmodule

`default_nettype wire

// ==== verilog/exception_arbiter.sv ====
`default_nettype none

module exception_arbiter (
    input  logic                   clk,
    input  mips_pkg::fault_flags_t flags,
    input  logic [7:0]             pending,
    input  mips_pkg::cp0_status_t  cp0_status,
    input  mips_pkg::word_t        epc,
    input  logic                   is_eret,
    output logic                   raise,
    output mips_pkg::exception_t   exc,
    output mips_pkg::word_t        target
);

    import mips_pkg::*;

    logic  int_taken;
    word_t epc_value;

    assign int_taken = cp0_status.IE && !cp0_status.EXL && (pending != 8'h00);

    // Delay slot restarts at the branch
    assign epc_value = flags.in_delay_slot ? (flags.pc - 32'd4) : flags.pc;

    // ------------------------------------------------------------------
    // Priority selection
    // ------------------------------------------------------------------
    always_comb begin
        raise   = 1'b1;
        target  = EXC_VECTOR;
        exc     = '0;
        exc.epc = epc_value;
        exc.bd  = flags.in_delay_slot;

        if (int_taken) begin
            exc.code = EXC_INT;
        end else if (flags.instr) begin
            exc.code        = EXC_ADEL;
            exc.badvaddr    = flags.vaddr;
            exc.badvaddr_we = 1'b1;
        end else if (flags.ri) begin
            exc.code = EXC_RI;
        end else if (flags.of) begin
            exc.code = EXC_OV;
        end else if (flags.sys) begin
            exc.code = EXC_SYS;
        end else if (flags.bp) begin
            exc.code = EXC_BP;
        end else if (flags.load) begin
            exc.code        = EXC_ADEL;
            exc.badvaddr    = flags.vaddr;
            exc.badvaddr_we = 1'b1;
        end else if (flags.save) begin
            exc.code        = EXC_ADES;
            exc.badvaddr    = flags.vaddr;
            exc.badvaddr_we = 1'b1;
        end else if (is_eret) begin
            exc         = '0;
            exc.is_eret = 1'b1;
            target      = epc;            // Return to stored EPC
        end else begin
            raise  = 1'b0;
            exc    = '0;
            target = '0;
        end
    end

    a_vector_target : assert property (
        @(posedge clk) (raise && !is_eret) |-> (target == EXC_VECTOR)
    ) else $error("exception_arbiter: redirect target is not the exception vector");

endmodule

`default_nettype wire

// ==== verilog/exception_checker.sv ====
`default_nettype none

module exception_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  mips_pkg::exec_data_t  in,
    input  logic [5:0]            ext_int,
    input  logic                  timer_interrupt,
    input  mips_pkg::cp0_status_t cp0_status,
    input  mips_pkg::cp0_cause_t  cp0_cause,
    input  mips_pkg::word_t       epc,
    output logic                  exception_valid,
    output mips_pkg::word_t       pcexception,
    output mips_pkg::exception_t  exception_data,
    output mips_pkg::exec_data_t  out
);

    import mips_pkg::*;

    exec_data_t   data;
    fault_flags_t flags;
    logic [7:0]   pending;
    logic         is_eret;
    logic         raise;
    exception_t   exc;
    word_t        target;
    logic         live;

    assign data    = arst_n ? in : '0;          // Nothing enters during reset
    assign is_eret = (data.instr.op == ERET);
    assign live    = !flush && data.valid;

    fault_detector u_fault (
        .rec   (data),
        .flags (flags)
    );

    interrupt_collector u_irq (
        .ext_int         (ext_int),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause),
        .pending         (pending)
    );

    exception_arbiter u_arb (
        .clk        (clk),
        .flags      (flags),
        .pending    (pending),
        .cp0_status (cp0_status),
        .epc        (epc),
        .is_eret    (is_eret),
        .raise      (raise),
        .exc        (exc),
        .target     (target)
    );

    // ------------------------------------------------------------------
    // Output gating
    // ------------------------------------------------------------------
    assign exception_valid = live && raise;
    assign pcexception     = live ? target : '0;
    assign exception_data  = live ? exc : '0;
    assign out             = (live && !raise) ? data : '0;   // Kill on exception

    a_kill_record : assert property (
        @(posedge clk) disable iff (!arst_n) exception_valid |-> (out == '0)
    ) else $error("exception_checker: record not killed on exception");

endmodule

`default_nettype wire

// ==== verilog/cp0_regs.sv ====
`default_nettype none

module cp0_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  exception_valid,
    input  mips_pkg::exception_t  exception_data,
    input  logic                  cp0_we,
    input  logic [4:0]            cp0_addr,
    input  mips_pkg::word_t       cp0_wdata,
    output mips_pkg::cp0_status_t status,
    output mips_pkg::cp0_cause_t  cause,
    output mips_pkg::cp0_view_t   view
);

    import mips_pkg::*;

    cp0_status_t status_r;
    cp0_cause_t  cause_r;
    word_t       epc_r;
    word_t       badvaddr_r;

    // ------------------------------------------------------------------
    // Register update
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_r   <= '0;
            cause_r    <= '0;
            epc_r      <= '0;
            badvaddr_r <= '0;
        end else if (exception_valid) begin
            if (exception_data.is_eret) begin
                status_r.EXL <= 1'b0;                 // Leave exception level
            end else begin
                status_r.EXL     <= 1'b1;
                cause_r.BD       <= exception_data.bd;
                cause_r.exc_code <= exception_data.code;
                epc_r            <= exception_data.epc;
                if (exception_data.badvaddr_we) begin
                    badvaddr_r <= exception_data.badvaddr;
                end
            end
        end else if (cp0_we) begin
            // MIPS bit layout of the written word
            case (cp0_addr)
                CP0_STATUS_ADDR: begin
                    status_r.IM  <= cp0_wdata[15:8];
                    status_r.EXL <= cp0_wdata[1];
                    status_r.IE  <= cp0_wdata[0];
                end
                CP0_CAUSE_ADDR: begin
                    cause_r.IP[1:0] <= cp0_wdata[9:8]; // Software interrupts only
                end
                CP0_EPC_ADDR: begin
                    epc_r <= cp0_wdata;
                end
                default: begin
                end
            endcase
        end
    end

    assign status = status_r;
    assign cause  = cause_r;

    assign view = '{
        status:   status_r,
        cause:    cause_r,
        epc:      epc_r,
        badvaddr: badvaddr_r
    };

    a_exl_set : assert property (
        @(posedge clk) disable iff (!arst_n)
        (exception_valid && !exception_data.is_eret) |=> status_r.EXL
    ) else $error("cp0_regs: EXL not set after exception");

endmodule

`default_nettype wire

// ==== verilog/exception_stage.sv ====
`default_nettype none

module exception_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  mips_pkg::exec_data_t in,
    input  logic [5:0]           ext_int,
    input  logic                 timer_interrupt,
    input  logic                 cp0_we,
    input  logic [4:0]           cp0_addr,
    input  mips_pkg::word_t      cp0_wdata,
    output logic                 exception_valid,
    output mips_pkg::word_t      pcexception,
    output mips_pkg::exception_t exception_data,
    output mips_pkg::exec_data_t out,
    output mips_pkg::cp0_view_t  cp0
);

    import mips_pkg::*;

    cp0_status_t status;
    cp0_cause_t  cause;

    exception_checker u_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (flush),
        .in              (in),
        .ext_int         (ext_int),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (status),
        .cp0_cause       (cause),
        .epc             (cp0.epc),         // ERET target
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_data  (exception_data),
        .out             (out)
    );

    cp0_regs u_cp0 (
        .clk             (clk),
        .arst_n          (arst_n),
        .exception_valid (exception_valid),
        .exception_data  (exception_data),
        .cp0_we          (cp0_we),
        .cp0_addr        (cp0_addr),
        .cp0_wdata       (cp0_wdata),
        .status          (status),
        .cause           (cause),
        .view            (cp0)
    );

endmodule

`default_nettype wire

// ==== tb/exception_monitor.sv ====
`default_nettype none

module exception_monitor (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [1:0]           phase,
    input  int                   test_num,
    input  logic                 exp_valid,
    input  mips_pkg::exc_code_t  exp_code,
    input  mips_pkg::word_t      exp_pc,
    input  logic                 exp_out_zero,
    input  mips_pkg::word_t      exp_epc,
    input  mips_pkg::word_t      exp_bad,
    input  logic                 exp_exl,
    input  mips_pkg::exec_data_t in,
    input  logic                 exception_valid,
    input  mips_pkg::word_t      pcexception,
    input  mips_pkg::exception_t exception_data,
    input  mips_pkg::exec_data_t out,
    input  mips_pkg::cp0_view_t  cp0,
    output int                   passed,
    output int                   failed
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    int         errs   = 0;
    int         n_pass = 0;
    int         n_fail = 0;
    exec_data_t exp_out;
    logic       exp_eret;
    logic       exp_bd;

    assign passed  = n_pass;
    assign failed  = n_fail;
    assign exp_out = exp_out_zero ? '0 : in;    // Record passes only when not killed

    // Only an ERET returns somewhere other than the vector
    assign exp_eret = exp_valid && (in.instr.op == ERET) && (exp_pc != EXC_VECTOR);
    assign exp_bd   = exp_valid && !exp_eret && in.in_delay_slot;

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: test %0d, %s is %h, expected %h",
                     $time, test_num, what, got, exp);
            errs++;
        end
    endtask

    task automatic rule(input logic ok, input string msg);
        if (!ok) begin
            $display("FAIL at %0d ns: test %0d, %s", $time, test_num, msg);
            errs++;
        end
    endtask

    // ------------------------------------------------------------------
    // Sampling at the falling edge, away from the drive edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (arst_n && phase == 2'd1) begin
            errs = 0;
            check("exception_valid", word_t'(exception_valid), word_t'(exp_valid));
            if (exp_valid) begin
                check("exception code", word_t'(exception_data.code), word_t'(exp_code));
                check("is_eret", word_t'(exception_data.is_eret), word_t'(exp_eret));
                check("BD", word_t'(exception_data.bd), word_t'(exp_bd));
            end else begin
                rule(exception_data === '0, "exception record is not cleared");
            end
            check("pcexception", pcexception, exp_pc);
            rule(out === exp_out, "outgoing record differs from the expected one");
        end else if (arst_n && phase == 2'd2) begin
            check("EPC", cp0.epc, exp_epc);
            check("BadVAddr", cp0.badvaddr, exp_bad);
            check("Status.EXL", word_t'(cp0.status.EXL), word_t'(exp_exl));
            if (exp_valid && !exp_eret) begin
                check("Cause.ExcCode", word_t'(cp0.cause.exc_code), word_t'(exp_code));
                check("Cause.BD", word_t'(cp0.cause.BD), word_t'(exp_bd));
            end
            if (errs == 0) begin
                n_pass++;
                $display("test %0d passed", test_num);
            end else begin
                n_fail++;
                $display("test %0d: %0d mismatches", test_num, errs);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_exception_stage.sv ====
`default_nettype none

module tb_exception_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    typedef struct packed {
        logic       we;
        logic [4:0] addr;
        word_t      data;
    } cp0_wr_t;

    typedef struct packed {
        exec_data_t rec;
        logic       flush;
        logic [6:0] irq;                // {timer, ext_int}
        cp0_wr_t    wr;
        logic       exp_valid;
        exc_code_t  exp_code;
        word_t      exp_pc;
        logic       exp_out_zero;
        word_t      exp_epc;            // Next cycle CP0 state
        word_t      exp_bad;
        logic       exp_exl;
    } test_row_t;

    localparam cp0_wr_t NO_WR = '0;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       flush;
    exec_data_t in;
    logic [5:0] ext_int;
    logic       timer_interrupt;
    logic       cp0_we;
    logic [4:0] cp0_addr;
    word_t      cp0_wdata;
    logic       exception_valid;
    word_t      pcexception;
    exception_t exception_data;
    exec_data_t out;
    cp0_view_t  cp0;

    test_row_t  rows[$];
    test_row_t  cur;
    logic [1:0] phase;
    int         test_num;
    int         passed;
    int         failed;
    int         cycles = 0;
    int         cycle_limit = 0;
    word_t      a1, a2, a3, a4, a5, a6;

    always #50 clk = ~clk;

    exception_stage dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (flush),
        .in              (in),
        .ext_int         (ext_int),
        .timer_interrupt (timer_interrupt),
        .cp0_we          (cp0_we),
        .cp0_addr        (cp0_addr),
        .cp0_wdata       (cp0_wdata),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_data  (exception_data),
        .out             (out),
        .cp0             (cp0)
    );

    exception_monitor u_monitor (
        .clk             (clk),
        .arst_n          (arst_n),
        .phase           (phase),
        .test_num        (test_num),
        .exp_valid       (cur.exp_valid),
        .exp_code        (cur.exp_code),
        .exp_pc          (cur.exp_pc),
        .exp_out_zero    (cur.exp_out_zero),
        .exp_epc         (cur.exp_epc),
        .exp_bad         (cur.exp_bad),
        .exp_exl         (cur.exp_exl),
        .in              (in),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_data  (exception_data),
        .out             (out),
        .cp0             (cp0),
        .passed          (passed),
        .failed          (failed)
    );

    // ------------------------------------------------------------------
    // Table helpers
    // ------------------------------------------------------------------
    function automatic word_t pc_at(int k);
        return word_t'(32'h0040_0000 + k * 16);
    endfunction

    function automatic word_t rand_addr(logic [1:0] low);
        word_t r;
        r = $urandom();
        return {r[31:2], low};
    endfunction

    // f is {valid, fetch error, ri, of, delay slot}
    function automatic exec_data_t make_rec(decoded_op_t op, word_t pc, word_t res,
                                            logic [4:0] f);
        exec_data_t r;
        r                 = '0;
        r.valid           = f[4];
        r.instr.op        = op;
        r.pcplus4         = pc + 32'd4;
        r.result          = res;
        r.exception_instr = f[3];
        r.exception_ri    = f[2];
        r.exception_of    = f[1];
        r.in_delay_slot   = f[0];
        return r;
    endfunction

    function automatic cp0_wr_t make_wr(logic [4:0] addr, word_t data);
        cp0_wr_t w;
        w.we   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    task automatic add(exec_data_t r, logic fl, logic [6:0] irq, cp0_wr_t w, logic ev,
                       exc_code_t code, word_t pcx, logic oz, word_t epc, word_t bad,
                       logic exl);
        rows.push_back('{r, fl, irq, w, ev, code, pcx, oz, epc, bad, exl});
    endtask

    // ------------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        arst_n          = 1'b0;
        flush           = 1'b0;
        in              = '0;
        ext_int         = '0;
        timer_interrupt = 1'b0;
        cp0_we          = 1'b0;
        cp0_addr        = '0;
        cp0_wdata       = '0;
        cur             = '0;
        phase           = 2'd0;
        test_num        = 0;
        void'($urandom(32'h80b69a1d));
        a1 = rand_addr(2'b10);
        a2 = rand_addr(2'b01);
        a3 = rand_addr(2'b11);
        a4 = rand_addr(2'b00);
        a5 = rand_addr(2'b01);
        a6 = rand_addr(2'b11);

        // Unaligned and aligned accesses
        add(make_rec(LW, pc_at(1), a1, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_ADEL, EXC_VECTOR, 1'b1, pc_at(1), a1, 1'b1);
        add(make_rec(LH, pc_at(2), a2, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_ADEL, EXC_VECTOR, 1'b1, pc_at(2), a2, 1'b1);
        add(make_rec(SW, pc_at(3), a3, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_ADES, EXC_VECTOR, 1'b1, pc_at(3), a3, 1'b1);
        add(make_rec(LW, pc_at(4), a4, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b0, EXC_INT, 32'd0, 1'b0, pc_at(3), a3, 1'b1);
        // Priority and delay slot
        add(make_rec(ALU, pc_at(5), 32'd1, 5'b10110), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_RI, EXC_VECTOR, 1'b1, pc_at(5), a3, 1'b1);
        add(make_rec(SYSCALL, pc_at(6), a5, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_SYS, EXC_VECTOR, 1'b1, pc_at(6), a3, 1'b1);
        add(make_rec(BREAK, pc_at(7), 32'd0, 5'b10001), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_BP, EXC_VECTOR, 1'b1, pc_at(7) - 32'd4, a3, 1'b1);
        add(make_rec(ERET, pc_at(8), 32'd0, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_INT, pc_at(7) - 32'd4, 1'b1, pc_at(7) - 32'd4, a3, 1'b0);
        // Interrupts
        add(make_rec(BREAK, pc_at(9), 32'd0, 5'b10000), 1'b0, 7'h01, NO_WR,
            1'b1, EXC_BP, EXC_VECTOR, 1'b1, pc_at(9), a3, 1'b1);
        add(make_rec(ALU, pc_at(10), 32'd0, 5'b00100), 1'b0, 7'h00,
            make_wr(CP0_STATUS_ADDR, 32'h0000_0401),
            1'b0, EXC_INT, 32'd0, 1'b1, pc_at(9), a3, 1'b0);
        add(make_rec(BREAK, pc_at(11), 32'd0, 5'b10000), 1'b0, 7'h01, NO_WR,
            1'b1, EXC_INT, EXC_VECTOR, 1'b1, pc_at(11), a3, 1'b1);
        add(make_rec(ALU, pc_at(12), 32'd0, 5'b10000), 1'b0, 7'h01, NO_WR,
            1'b0, EXC_INT, 32'd0, 1'b0, pc_at(11), a3, 1'b1);
        add(make_rec(LW, pc_at(13), a6, 5'b10000), 1'b1, 7'h00, NO_WR,
            1'b0, EXC_INT, 32'd0, 1'b1, pc_at(11), a3, 1'b1);
        // Software interrupt through Cause IP0
        add(make_rec(NOP, pc_at(14), 32'd0, 5'b00000), 1'b0, 7'h00,
            make_wr(CP0_STATUS_ADDR, 32'h0000_0101),
            1'b0, EXC_INT, 32'd0, 1'b1, pc_at(11), a3, 1'b0);
        add(make_rec(NOP, pc_at(15), 32'd0, 5'b00000), 1'b0, 7'h00,
            make_wr(CP0_CAUSE_ADDR, 32'h0000_0100),
            1'b0, EXC_INT, 32'd0, 1'b1, pc_at(11), a3, 1'b0);
        add(make_rec(ALU, pc_at(16), 32'd0, 5'b10000), 1'b0, 7'h00, NO_WR,
            1'b1, EXC_INT, EXC_VECTOR, 1'b1, pc_at(16), a3, 1'b1);

        cycle_limit = 2 * rows.size() * 2 + 20;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        foreach (rows[i]) begin
            @(posedge clk);
            in                         <= rows[i].rec;
            flush                      <= rows[i].flush;
            {timer_interrupt, ext_int} <= rows[i].irq;
            cp0_we                     <= rows[i].wr.we;
            cp0_addr                   <= rows[i].wr.addr;
            cp0_wdata                  <= rows[i].wr.data;
            cur                        <= rows[i];
            test_num                   <= i;
            phase                      <= 2'd1;
            @(posedge clk);
            phase <= 2'd2;                      // CP0 result visible now
        end

        @(posedge clk);
        phase                      <= 2'd0;
        in                         <= '0;
        flush                      <= 1'b0;
        {timer_interrupt, ext_int} <= '0;
        cp0_we                     <= 1'b0;
        @(negedge clk);
        $display("tests: %0d, passed: %0d, failed: %0d", rows.size(), passed, failed);
        if (failed == 0 && passed == rows.size()) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/mips_pkg.sv
verilog/fault_detector.sv
verilog/interrupt_collector.sv
verilog/exception_arbiter.sv
verilog/exception_checker.sv
verilog/cp0_regs.sv
verilog/exception_stage.sv
tb/exception_monitor.sv
tb/tb_exception_stage.sv

// ==== Makefile ====
# Verilator build for the exception stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exception_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
